/* sim.f */
+incdir+hw
hw/cpu_pkg.sv
hw/csr_if.sv
hw/if_stage.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/wb_csr_stage.sv
hw/cpu_top.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench, pass only if the log holds the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module cpu_tb \
    -o cpu_sim > build.log 2>&1 \
    && ./obj_dir/cpu_sim > sim.log 2>&1
grep -qx "Verification passed" sim.log && echo "sim passed" || { echo "sim failed, see sim.log"; exit 1; }

/* tests/cpu_patterns.txt */
# program: word count, then words from 0x1c000000; handler at 0x60 (fetch aliases on addr[9:2])
# trace: entry count, then one retirement per line as pc wnum wdata group
29
02801401 02bffc22 00100823 029ffc04
02bffc05 001004a6 02810007 298000e3
288000e8 00100509 0400c023 0400c00a
0281800b 0400302b 02801c0d 0400002d
0400000c 002b0000 0280040e 0400000f
00000000 00000000 00000000 00000000
04001410 04001811 02801231 04001831
06483800
25
1c000000 01 00000005 1
1c000004 02 00000004 1
1c000008 03 00000009 1
1c00000c 04 000007ff 1
1c000010 05 ffffffff 1
1c000014 06 00000004 1
1c000018 07 00000040 1
1c00001c 00 00000000 2
1c000020 08 00000009 2
1c000024 09 0000000e 2
1c000028 03 00000000 3
1c00002c 0a 00000009 3
1c000030 0b 00000060 3
1c000034 0b 00000000 3
1c000038 0d 00000007 3
1c00003c 0d 00000000 3
1c000040 0c 00000007 3
1c000044 00 00000000 4
00000060 10 000b0000 4
00000064 11 1c000044 4
00000068 11 1c000048 5
0000006c 11 1c000044 5
00000070 00 00000000 5
1c000048 0e 00000001 5
1c00004c 0f 00000007 5

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [ 3:0] inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [ 3:0] data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [ 3:0] debug_wb_rf_we;
    logic [ 4:0] debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256]; // 1 KiB so pc aliases on addr[9:2]
    logic [31:0] dmem [256];
    logic [31:0] exp_pc [64];
    logic [31:0] exp_wnum [64];
    logic [31:0] exp_wdata [64];
    int          exp_grp [64];
    int          trace_len;
    int          errors;
    int          grp_errors;
    int          grp_pass;
    int          grp_fail;
    int          cycles;
    int          limit;
    bit          reported;

    // sram requests latched mid-cycle and answered just after the edge
    logic        i_req, d_req;
    logic [31:0] i_addr, d_addr, d_wdata;
    logic [ 3:0] d_we;

    cpu_top dut0 (
        .clk(clk), .rst(rst),
        .inst_sram_en(inst_sram_en), .inst_sram_we(inst_sram_we),
        .inst_sram_addr(inst_sram_addr), .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        i_req   = inst_sram_en;
        i_addr  = inst_sram_addr;
        d_req   = data_sram_en;
        d_addr  = data_sram_addr;
        d_we    = data_sram_we;
        d_wdata = data_sram_wdata;
        if (!rst && inst_sram_en) begin
            compare_value("instruction fetch sram we", 32'd0, {28'd0, inst_sram_we});
        end
    end

    always @(posedge clk) begin
        #1;
        if (i_req) inst_sram_rdata = imem[i_addr[9:2]];
        if (d_req && d_we == 4'hf) begin
            dmem[d_addr[9:2]] = d_wdata; // word stores only
        end else if (d_req) begin
            data_sram_rdata = dmem[d_addr[9:2]];
        end
    end

    function automatic string group_name(input int id);
        case (id)
            1: return "straight-line arithmetic";
            2: return "store, load and interlock";
            3: return "csr read and write";
            4: return "syscall entry";
            5: return "ertn return";
            default: return "unknown group";
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        int          words;
        string       line;
        logic [31:0] w;
        fd = $fopen("tests/cpu_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_patterns.txt");
            errors++;
        end else begin
            n = $fgets(line, fd); // two comment lines
            n = $fgets(line, fd);
            n = $fscanf(fd, "%d", words);
            for (int i = 0; i < words; i++) begin
                n = $fscanf(fd, "%h", w);
                imem[i] = w;
            end
            n = $fscanf(fd, "%d", trace_len);
            for (int i = 0; i < trace_len; i++) begin
                n = $fscanf(fd, "%h %h %h %d", exp_pc[i], exp_wnum[i], exp_wdata[i],
                            exp_grp[i]);
                if (n != 4) begin
                    $display("pattern file: trace entry %0d is incomplete", i);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_retire(input int i);
        string tag;
        tag = $sformatf("%s, retire %0d", group_name(exp_grp[i]), i);
        compare_value({tag, " pc"}, exp_pc[i], debug_wb_pc);
        compare_value({tag, " wnum"}, exp_wnum[i], {27'd0, debug_wb_rf_wnum});
        if (exp_wnum[i] != 32'd0) begin
            compare_value({tag, " rf_we"}, 32'hf, {28'd0, debug_wb_rf_we});
            compare_value({tag, " wdata"}, exp_wdata[i], debug_wb_rf_wdata);
        end else begin
            compare_value({tag, " rf_we"}, 32'h0, {28'd0, debug_wb_rf_we});
        end
        if (i == trace_len - 1 || exp_grp[i + 1] != exp_grp[i]) begin
            if (errors == grp_errors) begin
                $display("test %0d (%s): ok", exp_grp[i], group_name(exp_grp[i]));
                grp_pass++;
            end else begin
                $display("test %0d (%s): FAILED", exp_grp[i], group_name(exp_grp[i]));
                grp_fail++;
            end
            grp_errors = errors;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: only part of the trace retired within %0d cycles", limit);
            reported = 1'b1;
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int idx;
        rst             = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        errors          = 0;
        grp_errors      = 0;
        grp_pass        = 0;
        grp_fail        = 0;
        cycles          = 0;
        limit           = 0;
        trace_len       = 0;
        reported        = 1'b0;
        idx             = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dmem[i] = 32'd0;
        end
        load_patterns();
        limit = trace_len * 8 + 100;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        while (idx < trace_len) begin
            @(negedge clk);
            if (debug_wb_pc != 32'd0) begin // nonzero pc marks a retirement
                check_retire(idx);
                idx++;
            end
        end
        $display("tests: %0d passed, %0d failed, %0d mismatches", grp_pass, grp_fail, errors);
        reported = 1'b1;
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    final begin
        if (!reported) $display("Verification failed");
    end
endmodule

`default_nettype wire

/* tests/cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       fs_valid,
    input wire logic       ds_valid,
    input wire logic       es_valid,
    input wire logic       ms_valid,
    input wire logic       ds_allowin,
    input wire fs_bus_t    fs_bus,
    input wire logic       flush,
    input wire logic       data_sram_en,
    input wire logic [3:0] data_sram_we
);
    a_reset_empty: assert property (@(posedge clk)
        rst |=> !(fs_valid || ds_valid || es_valid || ms_valid))
        else $error("pipeline valid set right after reset");

    // fetch is the only stage that can see back-pressure
    a_fs_hold: assert property (@(posedge clk) disable iff (rst)
        (fs_valid && !ds_allowin && !flush) |=> $stable(fs_bus))
        else $error("fetch bus changed while decode stalled");

    a_flush_empty: assert property (@(posedge clk) disable iff (rst)
        flush |=> !(fs_valid || ds_valid || es_valid || ms_valid))
        else $error("stage still valid after flush");

    a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
        (data_sram_we != 4'h0) |-> data_sram_en)
        else $error("data sram write without enable");
endmodule

bind cpu_top cpu_assertions u_asrt (
    .clk(clk), .rst(rst),
    .fs_valid(fs_valid), .ds_valid(ds_valid), .es_valid(es_valid), .ms_valid(ms_valid),
    .ds_allowin(ds_allowin), .fs_bus(fs_bus), .flush(flush),
    .data_sram_en(data_sram_en), .data_sram_we(data_sram_we)
);

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_sram_en,
    output logic [ 3:0] inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [ 3:0] data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [ 3:0] debug_wb_rf_we,
    output logic [ 4:0] debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic        ds_allowin, es_allowin, ms_allowin, ws_allowin;
    logic        fs_valid, ds_valid, es_valid, ms_valid;
    fs_bus_t     fs_bus;
    ds_bus_t     ds_bus;
    es_bus_t     es_bus;
    ms_bus_t     ms_bus;
    rf_hazard_t  es_hazard, ms_hazard, ws_hazard;
    logic        ws_we;
    logic [ 4:0] ws_dest;
    logic [31:0] ws_wdata;
    logic        flush;
    logic [31:0] flush_pc;

    csr_if csr_bus ();

    if_stage u_if (
        .clk(clk), .rst(rst),
        .inst_sram_en(inst_sram_en), .inst_sram_we(inst_sram_we),
        .inst_sram_addr(inst_sram_addr), .inst_sram_wdata(inst_sram_wdata),
        .inst_sram_rdata(inst_sram_rdata),
        .ds_allowin(ds_allowin), .fs_valid(fs_valid), .fs_bus(fs_bus),
        .flush(flush), .flush_pc(flush_pc)
    );

    id_stage u_id (
        .clk(clk), .rst(rst),
        .fs_valid(fs_valid), .fs_bus(fs_bus), .ds_allowin(ds_allowin),
        .ds_valid(ds_valid), .ds_bus(ds_bus), .es_allowin(es_allowin),
        .es_hazard(es_hazard), .ms_hazard(ms_hazard), .ws_hazard(ws_hazard),
        .ws_we(ws_we), .ws_dest(ws_dest), .ws_wdata(ws_wdata),
        .csr(csr_bus.decode), .flush(flush)
    );

    ex_stage u_ex (
        .clk(clk), .rst(rst),
        .ds_valid(ds_valid), .ds_bus(ds_bus), .es_allowin(es_allowin),
        .es_valid(es_valid), .es_bus(es_bus), .ms_allowin(ms_allowin),
        .es_hazard(es_hazard),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .flush(flush)
    );

    mem_stage u_mem (
        .clk(clk), .rst(rst),
        .es_valid(es_valid), .es_bus(es_bus), .ms_allowin(ms_allowin),
        .ms_valid(ms_valid), .ms_bus(ms_bus), .ws_allowin(ws_allowin),
        .ms_hazard(ms_hazard), .data_sram_rdata(data_sram_rdata), .flush(flush)
    );

    wb_csr_stage u_wb (
        .clk(clk), .rst(rst),
        .ms_valid(ms_valid), .ms_bus(ms_bus), .ws_allowin(ws_allowin),
        .ws_hazard(ws_hazard),
        .ws_we(ws_we), .ws_dest(ws_dest), .ws_wdata(ws_wdata),
        .csr(csr_bus.csr), .flush(flush), .flush_pc(flush_pc),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );
endmodule

`default_nettype wire

/* hw/wb_csr_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module wb_csr_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ms_valid,
    input  ms_bus_t     ms_bus,
    output logic        ws_allowin,
    output rf_hazard_t  ws_hazard,
    output logic        ws_we,
    output logic [ 4:0] ws_dest,
    output logic [31:0] ws_wdata,
    csr_if.csr          csr,
    output logic        flush,
    output logic [31:0] flush_pc,
    output logic [31:0] debug_wb_pc,
    output logic [ 3:0] debug_wb_rf_we,
    output logic [ 4:0] debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    logic        ws_valid;
    ms_bus_t     ws_ms;
    logic [1:0]  crmd_plv, prmd_pplv;
    logic        crmd_ie, prmd_pie;
    logic [5:0]  estat_ecode;
    logic [31:0] era, eentry, save0;
    logic        is_sys, is_ertn;

    assign ws_allowin = 1'b1; // commit never stalls
    assign is_sys     = ws_valid && ws_ms.op == OP_SYSCALL;
    assign is_ertn    = ws_valid && ws_ms.op == OP_ERTN;
    assign flush      = is_sys || is_ertn;
    assign flush_pc   = is_sys ? eentry : era;

    assign ws_we     = ws_valid && ws_ms.we;
    assign ws_dest   = ws_ms.dest;
    assign ws_wdata  = ws_ms.result;
    assign ws_hazard = '{valid: ws_valid, we: ws_ms.we, dest: ws_ms.dest};

    assign debug_wb_pc       = ws_valid ? ws_ms.pc : 32'd0; // zero when nothing retires
    assign debug_wb_rf_we    = {4{ws_we}};
    assign debug_wb_rf_wnum  = ws_ms.dest;
    assign debug_wb_rf_wdata = ws_ms.result;

    always_comb begin
        case (csr.num)
            `CSR_CRMD:   csr.rvalue = {29'd0, crmd_ie, crmd_plv};
            `CSR_PRMD:   csr.rvalue = {29'd0, prmd_pie, prmd_pplv};
            `CSR_ESTAT:  csr.rvalue = {10'd0, estat_ecode, 16'd0};
            `CSR_ERA:    csr.rvalue = era;
            `CSR_EENTRY: csr.rvalue = eentry;
            `CSR_SAVE0:  csr.rvalue = save0;
            default:     csr.rvalue = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_valid;
        end
        if (ms_valid) begin
            ws_ms <= ms_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {crmd_plv, crmd_ie, prmd_pplv, prmd_pie} <= '0;
            estat_ecode <= 6'd0;
            era         <= 32'd0;
            eentry      <= 32'd0;
            save0       <= 32'd0;
        end else if (is_sys) begin
            estat_ecode <= `ECODE_SYS;
            prmd_pplv   <= crmd_plv;
            prmd_pie    <= crmd_ie;
            crmd_plv    <= 2'd0; // enter kernel, irqs off
            crmd_ie     <= 1'b0;
            era         <= ws_ms.pc;
        end else if (is_ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr.we) begin
            case (csr.num)
                `CSR_CRMD:   {crmd_ie, crmd_plv} <= csr.wvalue[2:0];
                `CSR_PRMD:   {prmd_pie, prmd_pplv} <= csr.wvalue[2:0];
                `CSR_ERA:    era <= csr.wvalue;
                `CSR_EENTRY: eentry <= csr.wvalue;
                `CSR_SAVE0:  save0 <= csr.wvalue;
                default:     ; // estat ecode is hardware written
            endcase
        end
    end
endmodule

`default_nettype wire

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        es_valid,
    input  es_bus_t     es_bus,
    output logic        ms_allowin,
    output logic        ms_valid,
    output ms_bus_t     ms_bus,
    input  logic        ws_allowin,
    output rf_hazard_t  ms_hazard,
    input  logic [31:0] data_sram_rdata,
    input  logic        flush
);
    es_bus_t ms_es;

    assign ms_allowin = !ms_valid || ws_allowin;

    always_comb begin
        ms_bus = ms_es;
        if (ms_es.op == OP_LOAD) begin
            ms_bus.result = data_sram_rdata; // read issued in ex
        end
    end

    assign ms_hazard = '{valid: ms_valid, we: ms_es.we, dest: ms_es.dest};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_valid;
        end
        if (es_valid && ms_allowin) begin
            ms_es <= es_bus;
        end
    end
endmodule

`default_nettype wire

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ds_valid,
    input  ds_bus_t     ds_bus,
    output logic        es_allowin,
    output logic        es_valid,
    output es_bus_t     es_bus,
    input  logic        ms_allowin,
    output rf_hazard_t  es_hazard,
    output logic        data_sram_en,
    output logic [ 3:0] data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic        flush
);
    ds_bus_t     es_ds;
    logic [31:0] sum;
    logic        is_mem;

    assign sum        = es_ds.src1 + es_ds.src2; // alu result or address
    assign is_mem     = es_ds.op == OP_LOAD || es_ds.op == OP_STORE;
    assign es_allowin = !es_valid || ms_allowin;

    assign data_sram_en    = es_valid && is_mem && ms_allowin && !flush;
    assign data_sram_we    = (data_sram_en && es_ds.op == OP_STORE) ? 4'hf : 4'h0;
    assign data_sram_addr  = sum;
    assign data_sram_wdata = es_ds.st_data;

    assign es_bus = '{pc: es_ds.pc, op: es_ds.op, dest: es_ds.dest, we: es_ds.we,
                      result: (es_ds.op == OP_CSR) ? es_ds.csr_old : sum};
    assign es_hazard = '{valid: es_valid, we: es_ds.we, dest: es_ds.dest};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
        if (ds_valid && es_allowin) begin
            es_ds <= ds_bus;
        end
    end
endmodule

`default_nettype wire

/* hw/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module id_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fs_valid,
    input  fs_bus_t     fs_bus,
    output logic        ds_allowin,
    output logic        ds_valid,
    output ds_bus_t     ds_bus,
    input  logic        es_allowin,
    input  rf_hazard_t  es_hazard,
    input  rf_hazard_t  ms_hazard,
    input  rf_hazard_t  ws_hazard,
    input  logic        ws_we,
    input  logic [ 4:0] ws_dest,
    input  logic [31:0] ws_wdata,
    csr_if.decode       csr,
    input  logic        flush
);
    logic        ds_full;
    fs_bus_t     ds_fs;
    logic [31:0] rf [32];
    logic [31:0] inst;
    logic [4:0]  rd, rj, rk;
    logic [31:0] rj_val, rk_val, rd_val, imm, src2;
    op_e         op;
    logic        rf_we, use_rj, use_rk, use_rd, is_csrwr;
    logic        raw, serialize, ds_ready_go;

    function automatic logic hit(input rf_hazard_t h, input logic [4:0] r);
        return h.valid && h.we && r != 5'd0 && h.dest == r;
    endfunction

    assign inst     = ds_fs.inst;
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign imm      = {{20{inst[21]}}, inst[21:10]};
    assign is_csrwr = rj == 5'd1; // rj 0 is csrrd
    assign rj_val   = (rj == 5'd0) ? 32'd0 : rf[rj];
    assign rk_val   = (rk == 5'd0) ? 32'd0 : rf[rk];
    assign rd_val   = (rd == 5'd0) ? 32'd0 : rf[rd];

    always_comb begin
        op     = OP_ALU;
        rf_we  = 1'b0;
        use_rj = 1'b0;
        use_rk = 1'b0;
        use_rd = 1'b0;
        src2   = imm;
        if (inst[31:15] == `OPC_ADD_W) begin
            rf_we  = 1'b1;
            use_rj = 1'b1;
            use_rk = 1'b1;
            src2   = rk_val;
        end else if (inst[31:22] == `OPC_ADDI_W) begin
            rf_we  = 1'b1;
            use_rj = 1'b1;
        end else if (inst[31:22] == `OPC_LD_W) begin
            op     = OP_LOAD;
            rf_we  = 1'b1;
            use_rj = 1'b1;
        end else if (inst[31:22] == `OPC_ST_W) begin
            op     = OP_STORE;
            use_rj = 1'b1;
            use_rd = 1'b1;
        end else if (inst[31:24] == `OPC_CSR) begin
            op     = OP_CSR;
            rf_we  = 1'b1;
            use_rd = is_csrwr;
        end else if (inst[31:15] == `OPC_SYSCALL) begin
            op = OP_SYSCALL;
        end else if (inst == `INST_ERTN) begin
            op = OP_ERTN;
        end
    end

    // interlock, no forwarding paths
    assign raw = (use_rj && (hit(es_hazard, rj) || hit(ms_hazard, rj) || hit(ws_hazard, rj)))
              || (use_rk && (hit(es_hazard, rk) || hit(ms_hazard, rk) || hit(ws_hazard, rk)))
              || (use_rd && (hit(es_hazard, rd) || hit(ms_hazard, rd) || hit(ws_hazard, rd)));
    assign serialize = (op == OP_CSR || op == OP_SYSCALL || op == OP_ERTN)
                    && (es_hazard.valid || ms_hazard.valid || ws_hazard.valid);
    assign ds_ready_go = !raw && !serialize;
    assign ds_allowin  = !ds_full || (ds_ready_go && es_allowin);
    assign ds_valid    = ds_full && ds_ready_go;

    assign csr.num    = inst[23:10];
    assign csr.we     = ds_valid && es_allowin && op == OP_CSR && is_csrwr;
    assign csr.wvalue = rd_val;

    assign ds_bus = '{pc: ds_fs.pc, op: op, dest: rf_we ? rd : 5'd0, we: rf_we,
                      src1: rj_val, src2: src2, st_data: rd_val, csr_old: csr.rvalue};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ds_full <= 1'b0;
        end else if (ds_allowin) begin
            ds_full <= fs_valid;
        end
        if (fs_valid && ds_allowin) begin
            ds_fs <= fs_bus;
        end
    end

    always_ff @(posedge clk) begin
        if (ws_we && ws_dest != 5'd0) begin
            rf[ws_dest] <= ws_wdata;
        end
    end
endmodule

`default_nettype wire

/* hw/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module if_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_sram_en,
    output logic [ 3:0] inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    input  logic        ds_allowin,
    output logic        fs_valid,
    output fs_bus_t     fs_bus,
    input  logic        flush,
    input  logic [31:0] flush_pc
);
    logic [31:0] pf_pc; // next fetch address
    logic [31:0] fs_pc;
    logic [31:0] inst_buf;
    logic        inst_buf_valid;
    logic        fs_allowin;

    assign fs_allowin      = !fs_valid || ds_allowin;
    assign inst_sram_en    = fs_allowin;
    assign inst_sram_we    = 4'b0;
    assign inst_sram_addr  = pf_pc;
    assign inst_sram_wdata = 32'b0;

    always_ff @(posedge clk) begin
        if (rst) begin
            fs_valid <= 1'b0;
            pf_pc    <= `CPU_RESET_PC;
        end else if (flush) begin
            fs_valid <= 1'b0; // drop the word in flight
            pf_pc    <= flush_pc;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
            fs_pc    <= pf_pc;
            pf_pc    <= pf_pc + 32'd4;
        end
    end

    // sram output is only good for one cycle, hold it while decode stalls
    always_ff @(posedge clk) begin
        if (rst || flush || ds_allowin) begin
            inst_buf_valid <= 1'b0;
        end else if (fs_valid && !inst_buf_valid) begin
            inst_buf_valid <= 1'b1;
            inst_buf       <= inst_sram_rdata;
        end
    end

    assign fs_bus.pc   = fs_pc;
    assign fs_bus.inst = inst_buf_valid ? inst_buf : inst_sram_rdata;
endmodule

`default_nettype wire

/* hw/csr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface csr_if;
    logic [13:0] num;
    logic        we;
    logic [31:0] wvalue;
    logic [31:0] rvalue; // old value, comb from num

    modport decode (output num, output we, output wvalue, input rvalue);
    modport csr (input num, input we, input wvalue, output rvalue);
endinterface

`default_nettype wire

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_CSR,
        OP_SYSCALL,
        OP_ERTN
    } op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        logic [4:0]  dest;
        logic        we;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] st_data;
        logic [31:0] csr_old;
    } ds_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        op_e         op;
        logic [4:0]  dest;
        logic        we;
        logic [31:0] result;
    } es_bus_t;

    typedef es_bus_t ms_bus_t; // result already holds load data

    typedef struct packed {
        logic       valid;
        logic       we;
        logic [4:0] dest;
    } rf_hazard_t;

endpackage

`default_nettype wire

/* hw/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_RESET_PC 32'h1c00_0000

// csr numbers
`define CSR_CRMD   14'h000
`define CSR_PRMD   14'h001
`define CSR_ESTAT  14'h005
`define CSR_ERA    14'h006
`define CSR_EENTRY 14'h00c
`define CSR_SAVE0  14'h030

`define ECODE_SYS 6'h0b

// opcode match values, compared against the top bits of the word
`define OPC_ADD_W   17'h00020 // inst[31:15]
`define OPC_ADDI_W  10'h00a   // inst[31:22]
`define OPC_LD_W    10'h0a2   // inst[31:22]
`define OPC_ST_W    10'h0a6   // inst[31:22]
`define OPC_CSR     8'h04     // inst[31:24]
`define OPC_SYSCALL 17'h00056 // inst[31:15]
`define INST_ERTN   32'h0648_3800

`endif
